// File: all.f
design/rvfi_check_pkg.sv
design/check_ctrl.sv
design/trap_exc_checker.sv
design/trap_dbg_checker.sv
design/ack_tracker.sv
design/rvfi_trace_checker.sv
testbench/tb_rvfi_trace_checker.sv

// File: design/ack_tracker.sv
// Outstanding irq_ack and dbg_ack tracking with the interrupt-entry and orphan debug checks

`timescale 1ns/1ps

module ack_tracker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  rvfi_check_pkg::rvfi_retire_t retire_i,
  input  logic                        flush_i,
  input  logic                        irq_ack_i,
  input  logic                        dbg_ack_i,
  output rvfi_check_pkg::check_viol_t  viol_o
);

  import rvfi_check_pkg::*;

  logic                 irq_q;
  logic [DBG_CNT_W-1:0] dbg_cnt_q;
  logic                 dbg_entry;
  logic                 cnt_up;
  logic                 cnt_down;

  // First retirement of a debug handler
  assign dbg_entry = retire_i.valid && (retire_i.dbg != '0);

  // An ack and an entry in the same cycle cancel out
  assign cnt_up   = dbg_ack_i && !dbg_entry && (dbg_cnt_q != '1);
  assign cnt_down = dbg_entry && !dbg_ack_i && (dbg_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q     <= 1'b0;
      dbg_cnt_q <= '0;
    end else if (flush_i) begin
      irq_q     <= 1'b0;
      dbg_cnt_q <= '0;
    end else begin
      // A new ack wins over a retirement in the same cycle
      if (irq_ack_i) begin
        irq_q <= 1'b1;
      end else if (retire_i.valid) begin
        irq_q <= 1'b0;
      end
      if (cnt_up) begin
        dbg_cnt_q <= dbg_cnt_q + 1'b1;
      end else if (cnt_down) begin
        dbg_cnt_q <= dbg_cnt_q - 1'b1;
      end
    end
  end

  always_comb begin
    viol_o = '0;
    // The retirement after an irq_ack must be the interrupt handler entry
    viol_o.irq_intr   = !flush_i && retire_i.valid && irq_q && !retire_i.intr;
    // Debug entry with nothing acknowledged
    viol_o.dbg_orphan = !flush_i && dbg_entry && (dbg_cnt_q == '0);
  end

endmodule

// File: design/check_ctrl.sv
// Monitor FSM, sticky error flags and first-error capture of the RVFI checker

`timescale 1ns/1ps

module check_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       clear_i,
  input  rvfi_check_pkg::check_viol_t viol_i,
  output logic                       flush_o,
  output rvfi_check_pkg::check_viol_t err_o,
  output rvfi_check_pkg::check_id_e   first_err_o,
  output logic                       fail_o
);

  import rvfi_check_pkg::*;

  mon_state_e  state_q, state_d;
  check_viol_t err_q, err_d;
  check_id_e   first_q, first_d;
  logic        any_viol;
  logic        active;

  // Highest-priority failing check, i.e. the lowest enum value
  function automatic check_id_e pick_first(input check_viol_t v);
    if (v.trap_intr)        return CHK_TRAP_INTR;
    else if (v.trap_mcause) return CHK_TRAP_MCAUSE;
    else if (v.step_dbg)    return CHK_STEP_DBG;
    else if (v.trap_dbg)    return CHK_TRAP_DBG;
    else if (v.step_exc)    return CHK_STEP_EXC;
    else if (v.irq_intr)    return CHK_IRQ_INTR;
    else if (v.dbg_orphan)  return CHK_DBG_ORPHAN;
    else                    return CHK_NONE;
  endfunction

  assign any_viol = |viol_i;

  // Violations only count while monitoring runs undisturbed this cycle
  assign active = enable_i && !clear_i && (state_q != MON_OFF);

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    first_d = first_q;

    if (clear_i) begin
      // Restart from a clean slate, armed only if still enabled
      state_d = enable_i ? MON_ARMED : MON_OFF;
      err_d   = '0;
      first_d = CHK_NONE;
    end else if (!enable_i) begin
      // Pausing keeps the gathered flags
      state_d = MON_OFF;
    end else begin
      unique case (state_q)
        MON_OFF: state_d = MON_ARMED;
        MON_ARMED: begin
          if (any_viol) begin
            state_d = MON_FAILED;
          end
        end
        MON_FAILED: state_d = MON_FAILED;
        default: state_d = MON_OFF;
      endcase
    end

    if (active) begin
      err_d = err_q | viol_i;
      // The first error is taken once and then held until a clear
      if (any_viol && (first_q == CHK_NONE)) begin
        first_d = pick_first(viol_i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MON_OFF;
      err_q   <= '0;
      first_q <= CHK_NONE;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      first_q <= first_d;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Checkers drop their records whenever monitoring is off or restarts
  assign flush_o     = (state_q == MON_OFF) || clear_i;
  assign err_o       = err_q;
  assign first_err_o = first_q;
  assign fail_o      = (state_q == MON_FAILED);

endmodule

// File: design/rvfi_check_pkg.sv
// Shared widths, causes, trace record structs and state/check enums for the RVFI checker

package rvfi_check_pkg;

  ////////////////////////////////////////
  // Widths and fixed causes
  ////////////////////////////////////////

  // Low bits of mcause that carry the exception code
  localparam int unsigned CAUSE_W = 6;

  // Debug cause field, as in dcsr.cause and rvfi_dbg
  localparam int unsigned DBG_W = 3;

  // Debug cause reported for a single-step entry
  localparam logic [DBG_W-1:0] DBG_CAUSE_STEP = 3'd4;

  // Outstanding dbg_ack counter saturates at 2**DBG_CNT_W - 1
  localparam int unsigned DBG_CNT_W = 2;

  ////////////////////////////////////////
  // Retirement records
  ////////////////////////////////////////

  // Trap information of one retired instruction
  typedef struct packed {
    logic               exception;
    logic               debug;
    logic [CAUSE_W-1:0] exception_cause;
    logic [DBG_W-1:0]   debug_cause;
  } rvfi_trap_t;

  // One RVFI retirement with the CSR fields the checks look at
  typedef struct packed {
    logic               valid;
    logic               intr;
    rvfi_trap_t         trap;
    // Zero unless this retirement is the first of a debug handler
    logic [DBG_W-1:0]   dbg;
    logic [CAUSE_W-1:0] mcause;
    logic [DBG_W-1:0]   dcsr_cause;
    logic               dcsr_step;
    logic               debug_mode;
  } rvfi_retire_t;

  // One flag per check; the spare bit is never set
  typedef struct packed {
    logic trap_intr;
    logic trap_mcause;
    logic step_dbg;
    logic trap_dbg;
    logic step_exc;
    logic irq_intr;
    logic dbg_orphan;
    logic spare;
  } check_viol_t;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  // Check identifiers; a lower value wins when several fail together
  typedef enum logic [2:0] {
    CHK_NONE        = 3'd0,
    CHK_TRAP_INTR   = 3'd1,
    CHK_TRAP_MCAUSE = 3'd2,
    CHK_STEP_DBG    = 3'd3,
    CHK_TRAP_DBG    = 3'd4,
    CHK_STEP_EXC    = 3'd5,
    CHK_IRQ_INTR    = 3'd6,
    CHK_DBG_ORPHAN  = 3'd7
  } check_id_e;

  // Monitor state
  typedef enum logic [1:0] {
    MON_OFF    = 2'd0,
    MON_ARMED  = 2'd1,
    MON_FAILED = 2'd2
  } mon_state_e;

endpackage

// File: design/rvfi_trace_checker.sv
// Top level of the RVFI trace checker joining the control block and the three checkers

`timescale 1ns/1ps

module rvfi_trace_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  rvfi_check_pkg::rvfi_retire_t retire_i,
  input  logic                        irq_ack_i,
  input  logic                        dbg_ack_i,
  input  logic                        enable_i,
  input  logic                        clear_i,
  output rvfi_check_pkg::check_viol_t  err_o,
  output rvfi_check_pkg::check_id_e    first_err_o,
  output logic                        fail_o
);

  import rvfi_check_pkg::*;

  check_viol_t viol_exc;
  check_viol_t viol_dbg;
  check_viol_t viol_ack;
  check_viol_t viol;
  logic        flush;

  // Each checker sets only its own bits, so an OR merges them
  assign viol = viol_exc | viol_dbg | viol_ack;

  ////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////

  trap_exc_checker i_trap_exc_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .retire_i (retire_i),
    .flush_i  (flush),
    .viol_o   (viol_exc)
  );

  trap_dbg_checker i_trap_dbg_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .retire_i (retire_i),
    .flush_i  (flush),
    .viol_o   (viol_dbg)
  );

  ack_tracker i_ack_tracker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .retire_i  (retire_i),
    .flush_i   (flush),
    .irq_ack_i (irq_ack_i),
    .dbg_ack_i (dbg_ack_i),
    .viol_o    (viol_ack)
  );

  ////////////////////////////////////////
  // Control and reporting
  ////////////////////////////////////////

  check_ctrl i_check_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (enable_i),
    .clear_i     (clear_i),
    .viol_i      (viol),
    .flush_o     (flush),
    .err_o       (err_o),
    .first_err_o (first_err_o),
    .fail_o      (fail_o)
  );

endmodule

// File: design/trap_dbg_checker.sv
// Debug trap record with the debug-cause, single-step trap and single-step entry checks

`timescale 1ns/1ps

module trap_dbg_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  rvfi_check_pkg::rvfi_retire_t retire_i,
  input  logic                        flush_i,
  output rvfi_check_pkg::check_viol_t  viol_o
);

  import rvfi_check_pkg::*;

  // Control part of the record
  logic               seen_q;
  logic               dbg_q;
  logic               exc_q;
  // Payload part of the record
  logic [DBG_W-1:0]   dcause_q;
  logic [CAUSE_W-1:0] ecause_q;

  logic check_en;
  logic step_trap_bad;
  logic step_follow_bad;
  logic step_entry_ok;
  logic dbg_entry_step;

  // A retirement is compared only once a previous one has been recorded
  assign check_en = retire_i.valid && seen_q && !flush_i;

  assign dbg_entry_step = (retire_i.dbg == DBG_CAUSE_STEP);

  // Exception plus debug on one trap can only come from single stepping
  assign step_trap_bad = retire_i.valid && !flush_i &&
                         retire_i.trap.exception && retire_i.trap.debug &&
                         (retire_i.trap.debug_cause != DBG_CAUSE_STEP);

  // After a stepped exception the handler entry also enters debug on STEP
  assign step_entry_ok = dbg_entry_step &&
                         (retire_i.dcsr_cause == DBG_CAUSE_STEP) &&
                         retire_i.intr &&
                         (retire_i.mcause == ecause_q);

  assign step_follow_bad = check_en && exc_q && dbg_q && !step_entry_ok;

  ////////////////////////////////////////
  // Record of the previous retirement
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= 1'b0;
      dbg_q  <= 1'b0;
      exc_q  <= 1'b0;
    end else if (flush_i) begin
      seen_q <= 1'b0;
      dbg_q  <= 1'b0;
      exc_q  <= 1'b0;
    end else if (retire_i.valid) begin
      seen_q <= 1'b1;
      dbg_q  <= retire_i.trap.debug;
      exc_q  <= retire_i.trap.exception;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_i.valid) begin
      dcause_q <= retire_i.trap.debug_cause;
      ecause_q <= retire_i.trap.exception_cause;
    end
  end

  ////////////////////////////////////////
  // Violations
  ////////////////////////////////////////

  always_comb begin
    viol_o = '0;
    // A debug trap is followed by a debug entry with the same cause
    viol_o.trap_dbg = check_en && dbg_q &&
                      ((retire_i.dbg == '0) || (retire_i.dbg != dcause_q));
    // A STEP entry needs a STEP trap before it, unless an interrupt took it
    viol_o.step_dbg = check_en && (dcause_q != DBG_CAUSE_STEP) &&
                      dbg_entry_step && !retire_i.intr;
    // Checked on the trap itself and again on the retirement after it
    viol_o.step_exc = step_trap_bad || step_follow_bad;
  end

endmodule

// File: design/trap_exc_checker.sv
// Exception trap record with waive tracking and the interrupt-entry and mcause checks

`timescale 1ns/1ps

module trap_exc_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  rvfi_check_pkg::rvfi_retire_t retire_i,
  input  logic                        flush_i,
  output rvfi_check_pkg::check_viol_t  viol_o
);

  import rvfi_check_pkg::*;

  logic               pend_q;
  logic               waive_q;
  logic [CAUSE_W-1:0] cause_q;
  logic               waive_now;
  logic               waived;
  logic               check_en;

  // In debug mode or while stepping, mcause is not updated by the trap
  assign waive_now = retire_i.debug_mode || retire_i.dcsr_step;

  // The waive window runs from the capture through the checking retirement
  assign waived = waive_q || waive_now;

  assign check_en = retire_i.valid && pend_q && !waived && !flush_i;

  ////////////////////////////////////////
  // Record of the last retirement
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q  <= 1'b0;
      waive_q <= 1'b0;
    end else if (flush_i) begin
      pend_q  <= 1'b0;
      waive_q <= 1'b0;
    end else if (retire_i.valid) begin
      // Every retirement replaces the record, trap or not
      pend_q  <= retire_i.trap.exception;
      waive_q <= waive_now;
    end else if (pend_q) begin
      // Debug or step seen in any idle cycle also waives the check
      waive_q <= waived;
    end
  end

  // Cause is only looked at while pend_q is set
  always_ff @(posedge clk_i) begin
    if (retire_i.valid) begin
      cause_q <= retire_i.trap.exception_cause;
    end
  end

  ////////////////////////////////////////
  // Checks on the following retirement
  ////////////////////////////////////////

  always_comb begin
    viol_o = '0;
    // The handler entry must be flagged as an interrupt entry
    viol_o.trap_intr   = check_en && !retire_i.intr;
    // mcause must hold the code of the trap just taken
    viol_o.trap_mcause = check_en && (retire_i.mcause != cause_q);
  end

endmodule

// File: run.sh
#!/bin/sh
# Compile the RVFI trace checker testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_rvfi_trace_checker -o sim_tb

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
grep -q "Simulation PASSED" sim.log

// File: testbench/tb_rvfi_trace_checker.sv
// Testbench for the RVFI trace checker with directed and random stimulus, reference model and watchdog

`timescale 1ns/1ps

module tb_rvfi_trace_checker;

  import rvfi_check_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int N_RAND       = 1500;
  // Reset, directed part, random part with its clear pulses
  localparam int RUN_CYCLES      = RESET_CYCLES + 120 + 2 * N_RAND;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;
  localparam int CNT_SAT         = (1 << DBG_CNT_W) - 1;

  logic         clk_i;
  logic         rst_ni;
  rvfi_retire_t retire_i;
  logic         irq_ack_i;
  logic         dbg_ack_i;
  logic         enable_i;
  logic         clear_i;
  check_viol_t  err_o;
  check_id_e    first_err_o;
  logic         fail_o;

  logic         run_en;
  logic [31:0]  rng_state;

  // Generator memory of what the next retirement should answer
  logic               g_exc;
  logic               g_dbg;
  logic               g_irq;
  logic [CAUSE_W-1:0] g_cause;
  logic [DBG_W-1:0]   g_dcause;

  // Reference model state
  logic               m_pend;
  logic               m_waive;
  logic [CAUSE_W-1:0] m_cause;
  logic               m_seen;
  logic               m_dbg;
  logic               m_exc;
  logic [DBG_W-1:0]   m_dcause;
  logic [CAUSE_W-1:0] m_ecause;
  logic               m_irq;
  int                 m_cnt;
  mon_state_e         m_state;
  check_viol_t        m_err;
  check_id_e          m_first;

  rvfi_trace_checker i_rvfi_trace_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .retire_i    (retire_i),
    .irq_ack_i   (irq_ack_i),
    .dbg_ack_i   (dbg_ack_i),
    .enable_i    (enable_i),
    .clear_i     (clear_i),
    .err_o       (err_o),
    .first_err_o (first_err_o),
    .fail_o      (fail_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic rvfi_retire_t trap_rec(input logic exc, input logic dbg,
                                            input logic [CAUSE_W-1:0] ecause,
                                            input logic [DBG_W-1:0] dcause);
    rvfi_retire_t rec;
    rec = '0;
    rec.valid = 1'b1;
    rec.trap.exception = exc;
    rec.trap.debug = dbg;
    rec.trap.exception_cause = ecause;
    rec.trap.debug_cause = dcause;
    return rec;
  endfunction

  // A handler entry also writes the debug cause into dcsr
  function automatic rvfi_retire_t entry_rec(input logic intr, input logic [DBG_W-1:0] dbg,
                                             input logic [CAUSE_W-1:0] mcause);
    rvfi_retire_t rec;
    rec = '0;
    rec.valid = 1'b1;
    rec.intr = intr;
    rec.dbg = dbg;
    rec.dcsr_cause = dbg;
    rec.mcause = mcause;
    return rec;
  endfunction

  // Bit 7 of the vector is trap_intr, which has the highest priority
  function automatic check_id_e first_of(input check_viol_t v);
    check_id_e id;
    id = CHK_NONE;
    for (int i = 1; i <= 7; i++) begin
      if (v[8 - i] && (id == CHK_NONE)) begin
        id = check_id_e'(i[2:0]);
      end
    end
    return id;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  task automatic reset_model();
    m_pend = 1'b0;
    m_waive = 1'b0;
    m_cause = '0;
    m_seen = 1'b0;
    m_dbg = 1'b0;
    m_exc = 1'b0;
    m_dcause = '0;
    m_ecause = '0;
    m_irq = 1'b0;
    m_cnt = 0;
    m_state = MON_OFF;
    m_err = '0;
    m_first = CHK_NONE;
  endtask

  // Expected violations of one cycle, advancing the checker records
  function automatic check_viol_t ref_viol(input rvfi_retire_t r, input logic irq_ack,
                                           input logic dbg_ack, input logic flush);
    check_viol_t v;
    logic        waive_now;
    logic        entry;
    logic        step_ok;
    v = '0;
    waive_now = r.debug_mode || r.dcsr_step;
    entry = r.valid && (r.dbg != '0);
    step_ok = (r.dbg == DBG_CAUSE_STEP) && (r.dcsr_cause == DBG_CAUSE_STEP) &&
              r.intr && (r.mcause == m_ecause);
    if (!flush) begin
      // Exception trap needs an interrupt entry with its cause, unless waived
      if (r.valid && m_pend && !m_waive && !waive_now) begin
        v.trap_intr = !r.intr;
        v.trap_mcause = (r.mcause != m_cause);
      end
      // Exception together with debug is only legal as a single step
      if (r.valid && r.trap.exception && r.trap.debug &&
          (r.trap.debug_cause != DBG_CAUSE_STEP)) begin
        v.step_exc = 1'b1;
      end
      if (r.valid && m_seen) begin
        if (m_dbg && ((r.dbg == '0) || (r.dbg != m_dcause))) begin
          v.trap_dbg = 1'b1;
        end
        if (m_dbg && m_exc && !step_ok) begin
          v.step_exc = 1'b1;
        end
        if ((m_dcause != DBG_CAUSE_STEP) && (r.dbg == DBG_CAUSE_STEP) && !r.intr) begin
          v.step_dbg = 1'b1;
        end
      end
      v.irq_intr = r.valid && m_irq && !r.intr;
      v.dbg_orphan = entry && (m_cnt == 0);
    end
    if (r.valid) begin
      m_cause = r.trap.exception_cause;
      m_dcause = r.trap.debug_cause;
      m_ecause = r.trap.exception_cause;
    end
    if (flush) begin
      m_pend = 1'b0;
      m_waive = 1'b0;
      m_seen = 1'b0;
      m_dbg = 1'b0;
      m_exc = 1'b0;
      m_irq = 1'b0;
      m_cnt = 0;
    end else begin
      if (r.valid) begin
        m_pend = r.trap.exception;
        m_waive = waive_now;
        m_seen = 1'b1;
        m_dbg = r.trap.debug;
        m_exc = r.trap.exception;
      end else if (m_pend) begin
        m_waive = m_waive || waive_now;
      end
      if (irq_ack) begin
        m_irq = 1'b1;
      end else if (r.valid) begin
        m_irq = 1'b0;
      end
      if (dbg_ack && !entry && (m_cnt < CNT_SAT)) begin
        m_cnt = m_cnt + 1;
      end else if (entry && !dbg_ack && (m_cnt > 0)) begin
        m_cnt = m_cnt - 1;
      end
    end
    return v;
  endfunction

  task automatic advance_ctrl(input check_viol_t v, input logic en, input logic clr);
    if (en && !clr && (m_state != MON_OFF)) begin
      if ((v != '0) && (m_first == CHK_NONE)) begin
        m_first = first_of(v);
      end
      m_err = m_err | v;
    end
    if (clr) begin
      m_state = en ? MON_ARMED : MON_OFF;
      m_err = '0;
      m_first = CHK_NONE;
    end else if (!en) begin
      m_state = MON_OFF;
    end else if (m_state == MON_OFF) begin
      m_state = MON_ARMED;
    end else if ((m_state == MON_ARMED) && (v != '0)) begin
      m_state = MON_FAILED;
    end
  endtask

  // Compare at the falling edge, then step the model with the inputs of the next edge
  initial begin
    check_viol_t v;
    logic        flush;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        reset_model();
      end else begin
        assert ((err_o == m_err) && (first_err_o == m_first) &&
                (fail_o == (m_state == MON_FAILED)))
          else report_fail($sformatf("mismatch at %0t: err %h/%h first %s/%s fail %b/%b",
                                     $time, err_o, m_err, first_err_o.name(), m_first.name(),
                                     fail_o, m_state == MON_FAILED));
        flush = (m_state == MON_OFF) || clear_i;
        v = ref_viol(retire_i, irq_ack_i, dbg_ack_i, flush);
        advance_ctrl(v, enable_i, clear_i);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive(input rvfi_retire_t rec, input logic irq, input logic dack);
    @(posedge clk_i);
    retire_i  <= rec;
    irq_ack_i <= irq;
    dbg_ack_i <= dack;
    enable_i  <= run_en;
    clear_i   <= 1'b0;
  endtask

  task automatic restart();
    @(posedge clk_i);
    retire_i  <= '0;
    irq_ack_i <= 1'b0;
    dbg_ack_i <= 1'b0;
    enable_i  <= run_en;
    clear_i   <= 1'b1;
    g_exc = 1'b0;
    g_dbg = 1'b0;
    g_irq = 1'b0;
  endtask

  // One idle cycle lets the last record reach the outputs
  task automatic check_first(input check_id_e id);
    drive('0, 1'b0, 1'b0);
    @(negedge clk_i);
    assert ((first_err_o == id) && (fail_o == (id != CHK_NONE)) &&
            ((err_o == '0) == (id == CHK_NONE)))
      else report_fail($sformatf("mismatch at %0t: first_err_o %s, expected %s",
                                 $time, first_err_o.name(), id.name()));
  endtask

  task automatic random_cycle();
    logic [31:0]  r;
    rvfi_retire_t rec;
    logic         irq;
    logic         dack;
    r = next_rand();
    rec = '0;
    dack = 1'b0;
    irq = (r[23:20] == 4'h0);
    if (r[1:0] != 2'b00) begin
      if (g_exc || g_dbg || g_irq) begin
        // Well-formed entry answering the previous trap or irq_ack
        rec = entry_rec(g_exc || g_irq, g_dbg ? g_dcause : 3'd0, g_cause);
      end else begin
        case (r[4:2])
          3'd0: rec = trap_rec(1'b1, 1'b0, r[10:5], 3'd0);
          3'd1: rec = trap_rec(1'b0, 1'b1, r[10:5], (r[13:11] == 3'd0) ? 3'd1 : r[13:11]);
          3'd2: rec = trap_rec(1'b1, 1'b1, r[10:5], DBG_CAUSE_STEP);
          default: rec = entry_rec(1'b0, 3'd0, r[10:5]);
        endcase
        // The debug module acknowledges together with the debug trap
        dack = rec.trap.debug;
      end
      // Rare deliberate breaks
      if (r[31:26] == 6'd0) rec.intr = !rec.intr;
      if (r[31:26] == 6'd1) rec.mcause = rec.mcause ^ 6'd1;
      if (r[31:26] == 6'd2) rec.dbg = DBG_CAUSE_STEP;
      g_exc = rec.trap.exception;
      g_dbg = rec.trap.debug;
      g_cause = rec.trap.exception_cause;
      g_dcause = rec.trap.debug_cause;
      g_irq = 1'b0;
    end
    rec.debug_mode = (r[19:16] == 4'h0);
    rec.dcsr_step = (r[19:16] == 4'h1);
    if (irq) g_irq = 1'b1;
    drive(rec, irq, dack);
  endtask

  initial begin
    rvfi_retire_t rec;
    rst_ni = 1'b0;
    retire_i = '0;
    irq_ack_i = 1'b0;
    dbg_ack_i = 1'b0;
    enable_i = 1'b0;
    clear_i = 1'b0;
    run_en = 1'b1;
    rng_state = 32'h21e0;
    g_exc = 1'b0;
    g_dbg = 1'b0;
    g_irq = 1'b0;
    g_cause = '0;
    g_dcause = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Exception trap with a good entry, then a wrong mcause, then intr low
    restart();
    drive(trap_rec(1'b1, 1'b0, 6'd2, 3'd0), 1'b0, 1'b0);
    drive(entry_rec(1'b1, 3'd0, 6'd2), 1'b0, 1'b0);
    check_first(CHK_NONE);
    drive(trap_rec(1'b1, 1'b0, 6'd5, 3'd0), 1'b0, 1'b0);
    drive(entry_rec(1'b1, 3'd0, 6'd7), 1'b0, 1'b0);
    check_first(CHK_TRAP_MCAUSE);
    restart();
    drive(trap_rec(1'b1, 1'b0, 6'd3, 3'd0), 1'b0, 1'b0);
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b0);
    check_first(CHK_TRAP_INTR);

    // Debug mode in an idle cycle waives the pending exception
    restart();
    rec = '0;
    rec.debug_mode = 1'b1;
    drive(trap_rec(1'b1, 1'b0, 6'd3, 3'd0), 1'b0, 1'b0);
    drive(rec, 1'b0, 1'b0);
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b0);
    check_first(CHK_NONE);

    // Debug trap followed by a wrong cause, and by no debug entry at all
    restart();
    drive(trap_rec(1'b0, 1'b1, 6'd0, 3'd2), 1'b0, 1'b1);
    drive(entry_rec(1'b0, 3'd1, 6'd0), 1'b0, 1'b0);
    check_first(CHK_TRAP_DBG);
    restart();
    drive(trap_rec(1'b0, 1'b1, 6'd0, 3'd3), 1'b0, 1'b1);
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b0);
    check_first(CHK_TRAP_DBG);

    // Single-step trap with a wrong cause, then a good and a bad follow-up
    restart();
    drive(trap_rec(1'b1, 1'b1, 6'd4, 3'd1), 1'b0, 1'b1);
    check_first(CHK_STEP_EXC);
    restart();
    drive(trap_rec(1'b1, 1'b1, 6'd4, DBG_CAUSE_STEP), 1'b0, 1'b1);
    drive(entry_rec(1'b1, DBG_CAUSE_STEP, 6'd4), 1'b0, 1'b0);
    check_first(CHK_NONE);
    rec = entry_rec(1'b1, DBG_CAUSE_STEP, 6'd4);
    rec.dcsr_cause = 3'd1;
    drive(trap_rec(1'b1, 1'b1, 6'd4, DBG_CAUSE_STEP), 1'b0, 1'b1);
    drive(rec, 1'b0, 1'b0);
    check_first(CHK_STEP_EXC);

    // STEP entry with no STEP trap before it
    restart();
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b1);
    drive(entry_rec(1'b0, DBG_CAUSE_STEP, 6'd0), 1'b0, 1'b0);
    check_first(CHK_STEP_DBG);

    // irq_ack answered by an interrupt entry, then by a plain retirement
    restart();
    drive('0, 1'b1, 1'b0);
    drive(entry_rec(1'b1, 3'd0, 6'd5), 1'b0, 1'b0);
    check_first(CHK_NONE);
    drive('0, 1'b1, 1'b0);
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b0);
    check_first(CHK_IRQ_INTR);

    // Five acks saturate the counter at three, so the fourth entry is orphaned
    restart();
    repeat (5) drive('0, 1'b0, 1'b1);
    repeat (3) drive(entry_rec(1'b0, 3'd2, 6'd0), 1'b0, 1'b0);
    check_first(CHK_NONE);
    drive(entry_rec(1'b0, 3'd2, 6'd0), 1'b0, 1'b0);
    check_first(CHK_DBG_ORPHAN);

    // The broken entry arrives while still armed but with enable_i already low
    restart();
    drive(trap_rec(1'b1, 1'b0, 6'd3, 3'd0), 1'b0, 1'b0);
    run_en = 1'b0;
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b0);
    drive(entry_rec(1'b0, 3'd2, 6'd0), 1'b1, 1'b0);
    run_en = 1'b1;
    // A trap taken while still off is flushed and needs no entry once armed
    drive(trap_rec(1'b1, 1'b0, 6'd3, 3'd0), 1'b0, 1'b0);
    drive(entry_rec(1'b0, 3'd0, 6'd0), 1'b0, 1'b0);
    check_first(CHK_NONE);

    ////////////////////////////////////////
    // Random phase
    ////////////////////////////////////////

    for (int cyc = 0; cyc < N_RAND; cyc++) begin
      run_en = (cyc % 300) < 280;
      if ((cyc % 24) == 0) begin
        restart();
      end
      random_cycle();
    end

    drive('0, 1'b0, 1'b0);
    repeat (2) @(negedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

  // Ends a hung run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_fail("watchdog timeout, the stimulus did not finish in time");
  end

endmodule
